// ==== include/trace_trigger_defines.svh ====
/*
 * trace trigger constants
 * window bounds, address lane type code, segment letters, heartbeat divide
 */
`ifndef TRACE_TRIGGER_DEFINES_SVH
`define TRACE_TRIGGER_DEFINES_SVH

`define TT_LANES      4          // lanes per decoded packet
`define TT_ADDR_TYPE  4'd2       // type nibble of an address lane

// ====================================================================
// address windows, both bounds inclusive
// ====================================================================
`define TT_WIN1_LO    32'h0000ac00
`define TT_WIN1_HI    32'h0000acd6
`define TT_WIN2_LO    32'h0000accc   // single address
`define TT_WIN2_HI    32'h0000accc
`define TT_WIN3_LO    32'h0000abc0
`define TT_WIN3_HI    32'h0000ac00
`define TT_WIN4_LO    32'h00009054
`define TT_WIN4_HI    32'h00009096
`define TT_WIN5_LO    32'h000093de   // single address
`define TT_WIN5_HI    32'h000093de

// segment letters, active low, bit 6 is segment g
`define TT_SEG_E      7'b0000110
`define TT_SEG_R      7'b0101111
`define TT_SEG_O      7'b0100011
`define TT_SEG_C      7'b1000110
`define TT_SEG_L      7'b1000111
`define TT_SEG_A      7'b0001000
`define TT_SEG_BLANK  7'b1111111

`define TT_TICK_DIV   10_000_000 // about 200 ms per toggle at 50 MHz

`endif

// ==== hw/trace_trigger_pkg.sv ====
/*
 * trace trigger types
 * width typedefs plus the packet and window structs shared by all blocks
 */
`include "trace_trigger_defines.svh"

package trace_trigger_pkg;

	// ====================================================================
	// plain widths
	// ====================================================================
	typedef logic [3:0]  lane_type_t;  // per-lane type nibble
	typedef logic [31:0] trace_word_t; // lane payload, an address for type 2
	typedef logic [3:0]  trig_mode_t;  // switch selected mode
	typedef logic [31:0] vio_count_t;  // running violation count
	typedef logic [6:0]  seg_t;        // one digit, active low

	// one decoded packet, lane 0 in the low entries
	typedef struct packed {
		lane_type_t  [`TT_LANES-1:0] ltype; // type nibbles
		trace_word_t [`TT_LANES-1:0] word;  // lane words
	} trace_pkt_t;

	// window handed from the mode decode to the matcher
	typedef struct packed {
		trace_word_t lo;       // lower bound, inclusive
		trace_word_t hi;       // upper bound, inclusive
		logic        in_use;   // modes 1..5
		logic        vio_mode; // mode 0, strobe drives trigger
	} trig_window_t;

endpackage

// ==== hw/window_table.sv ====
/*
 * window table
 * registers the switch mode and decodes it into the active address window
 */
`include "trace_trigger_defines.svh"

module window_table (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	input  trace_trigger_pkg::trig_mode_t mode,
	output trace_trigger_pkg::trig_window_t win
);

	trace_trigger_pkg::trig_mode_t mode_q; // held mode, one cycle behind sw

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			mode_q <= '0; // back to violation mode
		else
			mode_q <= mode;
	end

	// ====================================================================
	// mode decode
	// ====================================================================
	always_comb begin
		win = '0; // unknown modes: nothing armed
		case (mode_q)
			4'd0: win.vio_mode = 1'b1;
			4'd1: begin
				win.lo = `TT_WIN1_LO;
				win.hi = `TT_WIN1_HI;
				win.in_use = 1'b1;
			end
			4'd2: begin
				win.lo = `TT_WIN2_LO;
				win.hi = `TT_WIN2_HI;
				win.in_use = 1'b1;
			end
			4'd3: begin
				win.lo = `TT_WIN3_LO;
				win.hi = `TT_WIN3_HI;
				win.in_use = 1'b1;
			end
			4'd4: begin
				win.lo = `TT_WIN4_LO;
				win.hi = `TT_WIN4_HI;
				win.in_use = 1'b1;
			end
			4'd5: begin
				win.lo = `TT_WIN5_LO;
				win.hi = `TT_WIN5_HI;
				win.in_use = 1'b1;
			end
			default: win = '0;
		endcase
	end

endmodule

// ==== hw/lane_match.sv ====
/*
 * lane matcher
 * checks all four lanes against the window, or passes the violation
 * strobe in mode 0, and registers the trigger
 */
`include "trace_trigger_defines.svh"

module lane_match (
	input  logic                            CLOCK_50,
	input  logic                            rst_n,
	input  trace_trigger_pkg::trace_pkt_t   pkt,
	input  trace_trigger_pkg::trig_window_t win,
	input  logic                            vio,
	output logic                            trigger
);

	logic [`TT_LANES-1:0] lane_hit; // per-lane window hit
	logic                 any_hit;  // some lane in window
	logic                 trig_d;   // next trigger value

	// ====================================================================
	// per-lane compare
	// ====================================================================
	genvar i;
	generate
		for (i = 0; i < `TT_LANES; i++) begin : g_lane
			// address lane, lo <= word <= hi
			assign lane_hit[i] = (pkt.ltype[i] == `TT_ADDR_TYPE) &&
			                     (pkt.word[i] >= win.lo) &&
			                     (pkt.word[i] <= win.hi);
		end
	endgenerate

	assign any_hit = |lane_hit;

	// source select
	always_comb begin
		if (win.vio_mode)
			trig_d = vio;       // checker strobe straight through
		else if (win.in_use)
			trig_d = any_hit;   // address window
		else
			trig_d = 1'b0;      // modes 6..15 stay quiet
	end

	// ====================================================================
	// output register
	// ====================================================================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			trigger <= 1'b0;
		else
			trigger <= trig_d; // one cycle after the packet
	end

endmodule

// ==== hw/violation_tracker.sv ====
/*
 * violation tracker
 * sticky flag set by the checker strobe and cleared from a key,
 * plus a free-running count of strobes
 */
module violation_tracker (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	input  logic                          vio,
	input  logic                          clear_n,
	output logic                          vio_flag,
	output trace_trigger_pkg::vio_count_t vio_count
);

	// ====================================================================
	// sticky flag
	// ====================================================================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			vio_flag <= 1'b0;
		end else begin
			if (vio)
				vio_flag <= 1'b1;  // set beats clear
			else if (!clear_n)
				vio_flag <= 1'b0;  // key held low
		end
	end

	// ====================================================================
	// strobe counter
	// ====================================================================
	// only reset brings it back down, the key leaves it alone
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			vio_count <= '0;
		else if (vio)
			vio_count <= vio_count + 1'b1; // wraps at 2^32
	end

endmodule

// ==== hw/status_panel.sv ====
/*
 * status panel
 * "Error" or "CLEAr" on the six digit display, and a heartbeat
 * toggled from a long tick divider
 */
`include "trace_trigger_defines.svh"

module status_panel #(
	parameter int tick_div = `TT_TICK_DIV
) (
	input  logic                    CLOCK_50,
	input  logic                    rst_n,
	input  logic                    vio_flag,
	output trace_trigger_pkg::seg_t hex0,
	output trace_trigger_pkg::seg_t hex1,
	output trace_trigger_pkg::seg_t hex2,
	output trace_trigger_pkg::seg_t hex3,
	output trace_trigger_pkg::seg_t hex4,
	output trace_trigger_pkg::seg_t hex5,
	output logic                    heartbeat
);

	localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

	logic [cnt_w-1:0] tick_cnt; // cycles since last tick
	logic             tick;     // last cycle of a period

	// ====================================================================
	// text, leftmost digit is hex5
	// ====================================================================
	always_comb begin
		hex5 = `TT_SEG_BLANK;
		hex0 = `TT_SEG_R; // both words end in r
		if (vio_flag) begin
			hex4 = `TT_SEG_E;
			hex3 = `TT_SEG_R;
			hex2 = `TT_SEG_R;
			hex1 = `TT_SEG_O;
		end else begin
			hex4 = `TT_SEG_C;
			hex3 = `TT_SEG_L;
			hex2 = `TT_SEG_E;
			hex1 = `TT_SEG_A;
		end
	end

	// ====================================================================
	// heartbeat divider
	// ====================================================================
	assign tick = (tick_cnt == cnt_w'(tick_div - 1));

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			tick_cnt  <= '0;
			heartbeat <= 1'b0;
		end else begin
			if (tick) begin
				tick_cnt  <= '0;
				heartbeat <= ~heartbeat; // once per tick_div cycles
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hw/trace_trigger.sv ====
/*
 * trace watch trigger, top level
 * mode decode, lane matcher, violation tracker and status display
 */
`include "trace_trigger_defines.svh"

module trace_trigger #(
	parameter int tick_div = `TT_TICK_DIV
) (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	input  trace_trigger_pkg::trace_pkt_t pkt,
	input  logic                          vio,
	input  logic [9:0]                    sw,
	input  logic [3:0]                    key,
	output logic                          trigger,
	output logic                          vio_flag,
	output trace_trigger_pkg::vio_count_t vio_count,
	output trace_trigger_pkg::seg_t       hex0,
	output trace_trigger_pkg::seg_t       hex1,
	output trace_trigger_pkg::seg_t       hex2,
	output trace_trigger_pkg::seg_t       hex3,
	output trace_trigger_pkg::seg_t       hex4,
	output trace_trigger_pkg::seg_t       hex5,
	output logic [9:0]                    ledr
);

	trace_trigger_pkg::trig_window_t win; // decoded window
	logic heartbeat;                      // slow blink

	// ====================================================================
	// trigger path
	// ====================================================================
	window_table u_window_table (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.mode     (sw[3:0]),
		.win      (win)
	);

	lane_match u_lane_match (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.pkt      (pkt),
		.win      (win),
		.vio      (vio),
		.trigger  (trigger)
	);

	// ====================================================================
	// violation status
	// ====================================================================
	violation_tracker u_violation_tracker (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.vio       (vio),
		.clear_n   (key[3]), // push key, low to clear
		.vio_flag  (vio_flag),
		.vio_count (vio_count)
	);

	status_panel #(.tick_div(tick_div)) u_status_panel (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.vio_flag  (vio_flag),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5),
		.heartbeat (heartbeat)
	);

	// leds: switch copy, activity, heartbeat
	assign ledr = {sw[9], trigger | vio | vio_flag, 7'd0, heartbeat};

endmodule

// ==== bench/trace_trigger_chk.sv ====
/*
 * trace trigger checks
 * bound onto the top level: count only rises, strobe sets the flag,
 * unknown modes keep the trigger quiet
 */
module trace_trigger_chk (
	input logic                            CLOCK_50,
	input logic                            rst_n,
	input logic                            vio,
	input logic                            vio_flag,
	input logic                            trigger,
	input trace_trigger_pkg::vio_count_t   vio_count,
	input trace_trigger_pkg::trig_window_t win
);

	int assert_fails = 0; // failed assertions so far

	// count moves up or holds, never back
	count_up: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$past(vio_count) <= vio_count)
		else begin
			$error("vio_count decreased outside reset");
			assert_fails = assert_fails + 1;
		end

	// strobe shows on the flag one cycle later
	flag_set: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		vio |=> vio_flag)
		else begin
			$error("vio strobe did not set vio_flag");
			assert_fails = assert_fails + 1;
		end

	// neither window nor strobe path armed
	quiet_mode: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(!win.in_use && !win.vio_mode) |=> !trigger)
		else begin
			$error("trigger rose with an unknown mode held");
			assert_fails = assert_fails + 1;
		end

endmodule

// ==== bench/trace_trigger_tb.sv ====
/*
 * trace trigger testbench
 * random packets, strobes, keys and switches checked against a cycle model
 */
`include "trace_trigger_defines.svh"

module trace_trigger_tb;

	localparam int reset_cycles = 16;
	localparam int test_cycles  = 4000;
	localparam int tick_div     = 8;    // short heartbeat period

	logic                          CLOCK_50;
	logic                          rst_n;
	trace_trigger_pkg::trace_pkt_t pkt;
	logic                          vio;
	logic [9:0]                    sw;
	logic [3:0]                    key;
	logic                          trigger;
	logic                          vio_flag;
	trace_trigger_pkg::vio_count_t vio_count;
	trace_trigger_pkg::seg_t       hex0;
	trace_trigger_pkg::seg_t       hex1;
	trace_trigger_pkg::seg_t       hex2;
	trace_trigger_pkg::seg_t       hex3;
	trace_trigger_pkg::seg_t       hex4;
	trace_trigger_pkg::seg_t       hex5;
	logic [9:0]                    ledr;

	integer seed;
	int     err_trig;   // trigger mismatches
	int     err_vio;    // flag and count mismatches
	int     err_disp;   // hex and led mismatches
	int     cyc;

	// model state
	trace_trigger_pkg::trig_mode_t m_mode;  // registered mode
	trace_trigger_pkg::vio_count_t m_count;
	logic                          m_trig;
	logic                          m_flag;
	logic                          m_hb;
	int                            m_tick;  // cycles into heartbeat period

	trace_trigger #(.tick_div(tick_div)) u_trace_trigger (
		.CLOCK_50 (CLOCK_50), .rst_n (rst_n), .pkt (pkt),
		.vio (vio), .sw (sw), .key (key),
		.trigger (trigger), .vio_flag (vio_flag), .vio_count (vio_count),
		.hex0 (hex0), .hex1 (hex1), .hex2 (hex2),
		.hex3 (hex3), .hex4 (hex4), .hex5 (hex5),
		.ledr (ledr)
	);

	bind trace_trigger trace_trigger_chk u_chk (
		.CLOCK_50 (CLOCK_50), .rst_n (rst_n), .vio (vio), .vio_flag (vio_flag),
		.trigger (trigger), .vio_count (vio_count), .win (win)
	);

	always #2 CLOCK_50 = ~CLOCK_50; // period 4

	// ====================================================================
	// reference model
	// ====================================================================
	// any address lane inside the window of this mode, bounds inclusive
	function automatic logic window_hit(input trace_trigger_pkg::trig_mode_t mode,
	                                    input trace_trigger_pkg::trace_pkt_t p);
		logic [31:0] lo;
		logic [31:0] hi;
		logic        hit;
		int          i;
		lo = 32'hffffffff; // empty window by default
		hi = 32'h0;
		case (mode)
			4'd1: {lo, hi} = {`TT_WIN1_LO, `TT_WIN1_HI};
			4'd2: {lo, hi} = {`TT_WIN2_LO, `TT_WIN2_HI};
			4'd3: {lo, hi} = {`TT_WIN3_LO, `TT_WIN3_HI};
			4'd4: {lo, hi} = {`TT_WIN4_LO, `TT_WIN4_HI};
			4'd5: {lo, hi} = {`TT_WIN5_LO, `TT_WIN5_HI};
			default: ;
		endcase
		hit = 1'b0;
		for (i = 0; i < `TT_LANES; i++)
			if (p.ltype[i] == `TT_ADDR_TYPE && p.word[i] >= lo && p.word[i] <= hi)
				hit = 1'b1;
		return hit;
	endfunction

	// one rising edge, fed with the inputs held across it
	task automatic model_edge();
		if (!rst_n) begin
			m_mode  = '0;
			m_trig  = 1'b0;
			m_flag  = 1'b0;
			m_count = '0;
			m_hb    = 1'b0;
			m_tick  = 0;
		end else begin
			if (m_mode == 4'd0)
				m_trig = vio;                   // strobe path
			else
				m_trig = window_hit(m_mode, pkt); // old window, new packet
			m_mode = sw[3:0];
			if (vio)
				m_flag = 1'b1;
			else if (!key[3])
				m_flag = 1'b0;
			if (vio)
				m_count = m_count + 32'd1;
			m_tick = m_tick + 1;
			if (m_tick == tick_div) begin
				m_tick = 0;
				m_hb   = ~m_hb;
			end
		end
	endtask

	// ====================================================================
	// stimulus
	// ====================================================================
	// mostly near a window bound, sometimes anywhere
	task automatic random_word(output trace_trigger_pkg::trace_word_t w);
		logic [31:0] r;
		logic [31:0] b;
		r = $random(seed);
		case (r[2:0])
			3'd0: b = `TT_WIN1_LO;
			3'd1: b = `TT_WIN1_HI;
			3'd2: b = `TT_WIN2_LO;
			3'd3: b = `TT_WIN3_LO;
			3'd4: b = `TT_WIN4_LO;
			3'd5: b = `TT_WIN4_HI;
			3'd6: b = `TT_WIN5_LO;
			default: b = {16'h0, r[31:16]};
		endcase
		if (r[5:3] == 3'd0)
			w = $random(seed);
		else
			w = b + {{30{r[7]}}, r[7:6]}; // bound -2 .. +1
	endtask

	task automatic drive_inputs(input logic in_reset);
		logic [31:0]                   r;
		trace_trigger_pkg::trace_word_t w;
		int                            i;
		r = $random(seed);
		vio = !in_reset && (r[2:0] == 3'd0);      // about 1 in 8
		key = {(r[6:4] != 3'd0), r[9:7]};          // clear about 1 in 8
		if (r[14:10] == 5'd0)                      // rare mode change
			sw[3:0] = r[15] ? r[19:16] : {1'b0, r[18:16]};
		sw[8:4] = r[24:20];
		sw[9]   = r[25];
		for (i = 0; i < `TT_LANES; i++) begin
			r = $random(seed);
			pkt.ltype[i] = (r[1:0] != 2'd0) ? `TT_ADDR_TYPE : r[5:2];
			random_word(w);
			pkt.word[i] = w;
		end
	endtask

	// ====================================================================
	// checks
	// ====================================================================
	task automatic report_fail(input string name, input logic [31:0] exp_v,
	                           input logic [31:0] act_v, inout int cnt);
		$display("Fail %s expected %h got %h at %0t", name, exp_v, act_v, $time);
		cnt = cnt + 1;
	endtask

	task automatic check_outputs();
		logic [6:0] exp_hex [6];
		logic [6:0] act_hex [6];
		logic [9:0] exp_ledr;
		int         i;
		exp_hex[5] = `TT_SEG_BLANK;
		exp_hex[4] = m_flag ? `TT_SEG_E : `TT_SEG_C;  // Error / CLEAr
		exp_hex[3] = m_flag ? `TT_SEG_R : `TT_SEG_L;
		exp_hex[2] = m_flag ? `TT_SEG_R : `TT_SEG_E;
		exp_hex[1] = m_flag ? `TT_SEG_O : `TT_SEG_A;
		exp_hex[0] = `TT_SEG_R;
		act_hex    = '{hex0, hex1, hex2, hex3, hex4, hex5};
		exp_ledr   = {sw[9], m_trig | vio | m_flag, 7'd0, m_hb};
		if (trigger !== m_trig)
			report_fail("trigger", 32'(m_trig), 32'(trigger), err_trig);
		if (vio_flag !== m_flag)
			report_fail("vio_flag", 32'(m_flag), 32'(vio_flag), err_vio);
		if (vio_count !== m_count)
			report_fail("vio_count", m_count, vio_count, err_vio);
		for (i = 0; i < 6; i++)
			if (act_hex[i] !== exp_hex[i])
				report_fail($sformatf("hex%0d", i), 32'(exp_hex[i]),
				            32'(act_hex[i]), err_disp);
		if (ledr !== exp_ledr)
			report_fail("ledr", 32'(exp_ledr), 32'(ledr), err_disp);
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================
	initial begin
		seed     = 32'h74f4;
		err_trig = 0;
		err_vio  = 0;
		err_disp = 0;
		CLOCK_50 = 1'b0;
		rst_n    = 1'b0;
		pkt      = '0;
		vio      = 1'b0;
		sw       = '0;
		key      = 4'hf;
		for (cyc = 0; cyc < reset_cycles + test_cycles; cyc++) begin
			@(posedge CLOCK_50);
			model_edge();
			#1;
			rst_n = (cyc >= reset_cycles - 1); // low across the first 16 edges
			drive_inputs(!rst_n);
			#1;
			check_outputs();                   // mid cycle, all settled
		end
		$display("errors: trigger %0d, violation %0d, display %0d, assertion %0d",
		         err_trig, err_vio, err_disp, u_trace_trigger.u_chk.assert_fails);
		if (err_trig + err_vio + err_disp + u_trace_trigger.u_chk.assert_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog, whole run plus some slack
	initial begin
		#((reset_cycles + test_cycles) * 4 + 200);
		$display("watchdog expired before the test sequence finished");
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== trace_trigger.f ====
+incdir+include
hw/trace_trigger_pkg.sv
hw/window_table.sv
hw/lane_match.sv
hw/violation_tracker.sv
hw/status_panel.sv
hw/trace_trigger.sv
bench/trace_trigger_chk.sv
bench/trace_trigger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the trace trigger testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module trace_trigger_tb \
	-f trace_trigger.f \
	-o trace_trigger_sim

# result is decided by the pass line in the simulator output
./obj_dir/trace_trigger_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null
